//--- sim.f
+incdir+verification
source/rv_slice_pkg.sv
source/inst_decoder.sv
source/decode_stage.sv
source/reg_file.sv
source/exec_stage.sv
source/result_stage.sv
source/rv_slice_top.sv
verification/rv_slice_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module rv_slice_tb \
  -f sim.f -o rv_slice_sim

./obj_dir/rv_slice_sim | tee sim.log

if grep -q "All tests passed" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- verification/rv_slice_ref.svh
// Reference model included by the slice testbench with LFSR stimulus, register mirror and records
`ifndef RV_SLICE_REF_SVH
`define RV_SLICE_REF_SVH

logic [15:0] lfsr_state = 16'd41672;
xlen_t       ref_regs [32] = '{default: '0};  // x0 is never written

// One Galois step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_state[0]};
    lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 16'hB400 : lfsr_state >> 1;
  end
  return v;
endfunction

// Registers kept to x0..x7 so results feed each other often
function automatic inst_t gen_inst();
  logic [3:0]  cls;
  reg_idx_t    rd, rs1, rs2;
  logic [2:0]  f3;
  logic [19:0] hi;
  logic [11:0] imm12;
  logic        alt;
  inst_t       w;
  cls   = 4'(rand_bits(4));
  rd    = reg_idx_t'(rand_bits(3));
  rs1   = reg_idx_t'(rand_bits(3));
  rs2   = reg_idx_t'(rand_bits(3));
  f3    = 3'(rand_bits(3));
  hi    = 20'(rand_bits(20));
  alt   = rand_bits(2) == 0;
  imm12 = hi[11:0];
  case (cls)
    4'd0, 4'd1, 4'd2: w = {alt ? f7_alt : f7_base, rs2, rs1, f3, rd, op_reg};
    4'd3, 4'd4, 4'd5: begin
      if (f3 == f3_sll || f3 == f3_sr) begin
        imm12[11:5] = alt ? f7_alt : f7_base;  // Shift forms
      end
      w = {imm12, rs1, f3, rd, op_imm};
    end
    4'd6:  w = {hi, rd, op_lui};
    4'd7:  w = {hi, rd, op_auipc};
    4'd8, 4'd9: w = {hi[6:0], rs2, rs1, f3, hi[11:7], op_branch};
    4'd10: w = {hi, rd, op_jal};
    4'd11: w = {imm12, rs1, (f3 == 3'b111) ? f3 : f3_jalr, rd, op_jalr};
    4'd12: w = {imm12, rs1, f3, rd, op_load};
    4'd13: w = {hi[6:0], rs2, rs1, f3, hi[11:7], op_store};
    4'd14: w = {imm12, rs1, f3, rd, alt ? op_fence : op_system};
    default: w = rand_bits(32);  // Mostly unknown encodings
  endcase
  return w;
endfunction

// RV32I arithmetic with legal cleared on an encoding the ISA does not define
function automatic xlen_t alu_expect(input logic [2:0] f3, input logic [6:0] f7,
                                     input logic imm_form, input xlen_t x, input xlen_t y,
                                     output logic legal);
  xlen_t r;
  legal = imm_form || f7 == 7'h00;
  case (f3)
    3'b000: begin
      if (!imm_form && f7 == 7'h20) begin
        r     = x - y;
        legal = 1'b1;
      end else begin
        r = x + y;
      end
    end
    3'b001: begin
      r     = x << y[4:0];
      legal = f7 == 7'h00;
    end
    3'b010: r = xlen_t'($signed(x) < $signed(y));
    3'b011: r = xlen_t'(x < y);
    3'b100: r = x ^ y;
    3'b101: begin
      r     = f7[5] ? xlen_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
      legal = f7 == 7'h00 || f7 == 7'h20;
    end
    3'b110: r = x | y;
    default: r = x & y;
  endcase
  return r;
endfunction

// Expected record for one instruction with the mirror updated in program order
function automatic void predict(input inst_t w, input xlen_t pc);
  xlen_t    a, b, i_imm, wd, tgt;
  reg_idx_t rd;
  logic     ok, tk, br, jmp, we;
  int       slot;
  a     = ref_regs[w[19:15]];
  b     = ref_regs[w[24:20]];
  i_imm = {{20{w[31]}}, w[31:20]};
  rd    = w[11:7];
  ok    = 1'b1;
  tk    = 1'b0;
  br    = 1'b0;
  jmp   = 1'b0;
  wd    = '0;
  tgt   = '0;
  case (w[6:0])
    op_lui:   wd = {w[31:12], 12'h000};
    op_auipc: wd = pc + {w[31:12], 12'h000};
    op_jal: begin
      jmp = 1'b1;
      wd  = pc + 32'd4;
      tgt = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    end
    op_jalr: begin
      ok  = w[14:12] == 3'b000;
      jmp = ok;
      wd  = pc + 32'd4;
      tgt = (a + i_imm) & 32'hFFFF_FFFE;
    end
    op_branch: begin
      br  = 1'b1;
      tgt = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      case (w[14:12])
        3'b000: tk = a == b;
        3'b001: tk = a != b;
        3'b100: tk = $signed(a) < $signed(b);
        3'b101: tk = $signed(a) >= $signed(b);
        3'b110: tk = a < b;
        3'b111: tk = a >= b;
        default: ok = 1'b0;
      endcase
    end
    op_imm:  wd = alu_expect(w[14:12], w[31:25], 1'b1, a, i_imm, ok);
    op_reg:  wd = alu_expect(w[14:12], w[31:25], 1'b0, a, b, ok);
    default: ok = 1'b0;  // Memory, fence, system, unknown
  endcase
  tk = ok && (tk || jmp);
  we = ok && !br && rd != '0;
  if (we) begin
    ref_regs[rd] = wd;
  end
  slot = exp_tail % EXP_SLOTS;
  exp_pc[slot]     = pc;
  exp_dest[slot]   = rd;
  exp_we[slot]     = we;
  exp_wdata[slot]  = wd;
  exp_taken[slot]  = tk;
  exp_target[slot] = tgt;
  exp_trap[slot]   = !ok;
  exp_tchk[slot]   = ok && (br || jmp);
  exp_tail++;
endfunction

`endif

//--- verification/rv_slice_tb.sv
// Testbench top that sends random RV32I instructions under credits and checks records by assertions
`default_nettype none

module rv_slice_tb import rv_slice_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_INST  = 400;
  localparam int EXP_SLOTS = 512;

  logic     clk = 1'b0;
  logic     rst;
  logic     inst_valid;
  inst_t    inst;
  xlen_t    inst_pc;
  logic     res_credit = 1'b0;
  logic     inst_credit, res_valid, res_we, res_taken, res_trap;
  xlen_t    res_pc, res_wdata, res_target;
  reg_idx_t res_rd;

  // Expected records pushed at send time
  xlen_t    exp_pc     [EXP_SLOTS];
  reg_idx_t exp_dest   [EXP_SLOTS];
  logic     exp_we     [EXP_SLOTS];
  xlen_t    exp_wdata  [EXP_SLOTS];
  logic     exp_taken  [EXP_SLOTS];
  xlen_t    exp_target [EXP_SLOTS];
  logic     exp_trap   [EXP_SLOTS];
  logic     exp_tchk   [EXP_SLOTS];  // Target only defined for branches and jumps
  int       exp_head = 0;
  int       exp_tail = 0;

  int sent_cnt    = 0;
  int credit_rx   = 0;  // inst_credit pulses seen
  int beats       = 0;
  int credit_seen = 0;  // res_credit pulses seen by the DUT
  int rx_cycle    = 0;

  xlen_t    head_pc, head_wdata, head_target;
  reg_idx_t head_rd;
  logic     head_we, head_taken, head_trap, head_tchk;

  `include "rv_slice_ref.svh"

  always #2 clk = ~clk;

  rv_slice_top DUT (
    .clk         (clk),
    .rst         (rst),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .inst_pc     (inst_pc),
    .inst_credit (inst_credit),
    .res_valid   (res_valid),
    .res_pc      (res_pc),
    .res_rd      (res_rd),
    .res_we      (res_we),
    .res_wdata   (res_wdata),
    .res_taken   (res_taken),
    .res_target  (res_target),
    .res_trap    (res_trap),
    .res_credit  (res_credit)
  );

  assign head_pc     = exp_pc[exp_head % EXP_SLOTS];
  assign head_rd     = exp_dest[exp_head % EXP_SLOTS];
  assign head_we     = exp_we[exp_head % EXP_SLOTS];
  assign head_wdata  = exp_wdata[exp_head % EXP_SLOTS];
  assign head_taken  = exp_taken[exp_head % EXP_SLOTS];
  assign head_target = exp_target[exp_head % EXP_SLOTS];
  assign head_trap   = exp_trap[exp_head % EXP_SLOTS];
  assign head_tchk   = exp_tchk[exp_head % EXP_SLOTS];

  always @(posedge clk) begin
    if (rst) begin
      exp_head    <= 0;
      beats       <= 0;
      credit_seen <= 0;
      credit_rx   <= 0;
    end else begin
      if (res_valid) begin
        exp_head <= exp_head + 1;  // Pop after the assertions sampled the head
        beats    <= beats + 1;
      end
      if (res_credit) begin
        credit_seen <= credit_seen + 1;
      end
      if (inst_credit) begin
        credit_rx <= credit_rx + 1;
      end
    end
  end

  // Receiver returns owed credits, but holds them back one stretch in three
  always @(posedge clk) begin
    #1;
    rx_cycle   = rx_cycle + 1;
    res_credit = !rst && beats > credit_seen && (rx_cycle / 24) % 3 != 1;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input xlen_t got, input xlen_t want);
    stop_with_failure($sformatf("Fail %s got 0x%08h expected 0x%08h", name, got, want));
  endtask

  a_pending: assert property (@(posedge clk) disable iff (rst) res_valid |-> exp_head < exp_tail)
    else stop_with_failure("A record came out with no instruction outstanding");
  a_pc: assert property (@(posedge clk) disable iff (rst) res_valid |-> res_pc == head_pc)
    else report_mismatch("res_pc", $sampled(res_pc), $sampled(head_pc));
  a_rd: assert property (@(posedge clk) disable iff (rst) res_valid |-> res_rd == head_rd)
    else report_mismatch("res_rd", xlen_t'($sampled(res_rd)), xlen_t'($sampled(head_rd)));
  a_we: assert property (@(posedge clk) disable iff (rst) res_valid |-> res_we == head_we)
    else report_mismatch("res_we", xlen_t'($sampled(res_we)), xlen_t'($sampled(head_we)));
  a_trap: assert property (@(posedge clk) disable iff (rst) res_valid |-> res_trap == head_trap)
    else report_mismatch("res_trap", xlen_t'($sampled(res_trap)), xlen_t'($sampled(head_trap)));
  a_taken: assert property (@(posedge clk) disable iff (rst)
    res_valid |-> res_taken == head_taken)
    else report_mismatch("res_taken", xlen_t'($sampled(res_taken)),
                         xlen_t'($sampled(head_taken)));
  a_wdata: assert property (@(posedge clk) disable iff (rst)
    res_valid && head_we |-> res_wdata == head_wdata)
    else report_mismatch("res_wdata", $sampled(res_wdata), $sampled(head_wdata));
  a_target: assert property (@(posedge clk) disable iff (rst)
    res_valid && head_tchk |-> res_target == head_target)
    else report_mismatch("res_target", $sampled(res_target), $sampled(head_target));
  a_out_credit: assert property (@(posedge clk) disable iff (rst)
    res_valid |-> beats < OUT_CREDITS + credit_seen)
    else stop_with_failure("A record was sent without an output credit");
  a_in_credit: assert property (@(posedge clk) disable iff (rst) inst_credit == res_valid)
    else stop_with_failure("inst_credit did not pulse exactly with a sent record");

  // Waits for an input credit, then drives one instruction for a single cycle
  task automatic send_inst(input inst_t w, input xlen_t pc);
    int waited;
    waited = 0;
    while (sent_cnt - credit_rx >= RESULT_DEPTH) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > 200) begin
        stop_with_failure("Timed out waiting for an input credit");
      end
    end
    inst_valid = 1'b1;
    inst       = w;
    inst_pc    = pc;
    predict(w, pc);
    sent_cnt++;
    @(posedge clk);
    #1;
    inst_valid = 1'b0;
  endtask

  initial begin
    xlen_t pc;
    int    waited;
    pc         = 32'h0000_1000;
    waited     = 0;
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    inst_pc    = '0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int n = 0; n < NUM_INST; n++) begin
      send_inst(gen_inst(), pc);
      pc = pc + 32'd4;  // Jumps are only reported and never redirect
    end
    while (exp_head != exp_tail) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > 1000) begin
        stop_with_failure("Timed out waiting for the slice to drain");
      end
    end
    if (credit_rx != sent_cnt) begin
      stop_with_failure("Input credits did not all return after the slice drained");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- source/rv_slice_top.sv
// Top level of the RV32I slice joining the decode, execute and result stages
`default_nettype none

module rv_slice_top import rv_slice_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     inst_valid,
  input  inst_t    inst,
  input  xlen_t    inst_pc,
  output logic     inst_credit,
  output logic     res_valid,
  output xlen_t    res_pc,
  output reg_idx_t res_rd,
  output logic     res_we,
  output xlen_t    res_wdata,
  output logic     res_taken,
  output xlen_t    res_target,
  output logic     res_trap,
  input  logic     res_credit
);

  // Decode to execute
  logic     dec_valid, dec_use_imm, dec_use_pc, dec_writes_rd;
  logic     dec_is_branch, dec_is_jal, dec_is_jalr, dec_trap;
  reg_idx_t dec_rs1, dec_rs2, dec_rd;
  xlen_t    dec_imm, dec_pc;
  alu_op_e  dec_alu_op;
  cmp_op_e  dec_cmp_op;

  // Execute to result
  logic     ex_valid, ex_we, ex_taken, ex_trap;
  xlen_t    ex_pc, ex_wdata, ex_target;
  reg_idx_t ex_rd;

  decode_stage u_decode (
    .clk           (clk),
    .rst           (rst),
    .inst_valid    (inst_valid),
    .inst          (inst),
    .inst_pc       (inst_pc),
    .dec_valid     (dec_valid),
    .dec_rs1       (dec_rs1),
    .dec_rs2       (dec_rs2),
    .dec_rd        (dec_rd),
    .dec_imm       (dec_imm),
    .dec_alu_op    (dec_alu_op),
    .dec_cmp_op    (dec_cmp_op),
    .dec_use_imm   (dec_use_imm),
    .dec_use_pc    (dec_use_pc),
    .dec_writes_rd (dec_writes_rd),
    .dec_is_branch (dec_is_branch),
    .dec_is_jal    (dec_is_jal),
    .dec_is_jalr   (dec_is_jalr),
    .dec_trap      (dec_trap),
    .dec_pc        (dec_pc)
  );

  exec_stage u_exec (
    .clk           (clk),
    .rst           (rst),
    .dec_valid     (dec_valid),
    .dec_rs1       (dec_rs1),
    .dec_rs2       (dec_rs2),
    .dec_rd        (dec_rd),
    .dec_imm       (dec_imm),
    .dec_alu_op    (dec_alu_op),
    .dec_cmp_op    (dec_cmp_op),
    .dec_use_imm   (dec_use_imm),
    .dec_use_pc    (dec_use_pc),
    .dec_writes_rd (dec_writes_rd),
    .dec_is_branch (dec_is_branch),
    .dec_is_jal    (dec_is_jal),
    .dec_is_jalr   (dec_is_jalr),
    .dec_trap      (dec_trap),
    .dec_pc        (dec_pc),
    .ex_valid      (ex_valid),
    .ex_pc         (ex_pc),
    .ex_wdata      (ex_wdata),
    .ex_target     (ex_target),
    .ex_rd         (ex_rd),
    .ex_we         (ex_we),
    .ex_taken      (ex_taken),
    .ex_trap       (ex_trap)
  );

  result_stage u_result (
    .clk         (clk),
    .rst         (rst),
    .ex_valid    (ex_valid),
    .ex_pc       (ex_pc),
    .ex_rd       (ex_rd),
    .ex_we       (ex_we),
    .ex_wdata    (ex_wdata),
    .ex_taken    (ex_taken),
    .ex_target   (ex_target),
    .ex_trap     (ex_trap),
    .res_credit  (res_credit),
    .res_valid   (res_valid),
    .res_pc      (res_pc),
    .res_rd      (res_rd),
    .res_we      (res_we),
    .res_wdata   (res_wdata),
    .res_taken   (res_taken),
    .res_target  (res_target),
    .res_trap    (res_trap),
    .inst_credit (inst_credit)
  );

endmodule

`default_nettype wire

//--- source/result_stage.sv
// Result queue that sends records against output credits and returns input credits
`default_nettype none

module result_stage import rv_slice_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     ex_valid,
  input  xlen_t    ex_pc,
  input  reg_idx_t ex_rd,
  input  logic     ex_we,
  input  xlen_t    ex_wdata,
  input  logic     ex_taken,
  input  xlen_t    ex_target,
  input  logic     ex_trap,
  input  logic     res_credit,
  output logic     res_valid,
  output xlen_t    res_pc,
  output reg_idx_t res_rd,
  output logic     res_we,
  output xlen_t    res_wdata,
  output logic     res_taken,
  output xlen_t    res_target,
  output logic     res_trap,
  output logic     inst_credit
);

  xlen_t    q_pc     [RESULT_DEPTH];
  reg_idx_t q_rd     [RESULT_DEPTH];
  logic     q_we     [RESULT_DEPTH];
  xlen_t    q_wdata  [RESULT_DEPTH];
  logic     q_taken  [RESULT_DEPTH];
  xlen_t    q_target [RESULT_DEPTH];
  logic     q_trap   [RESULT_DEPTH];

  logic [$clog2(RESULT_DEPTH)-1:0] wr_ptr, rd_ptr;
  credit_cnt_t count, credits;
  logic send;

  assign send = count != '0 && credits != '0;

  always_ff @(posedge clk) begin
    if (ex_valid) begin
      q_pc[wr_ptr]     <= ex_pc;
      q_rd[wr_ptr]     <= ex_rd;
      q_we[wr_ptr]     <= ex_we;
      q_wdata[wr_ptr]  <= ex_wdata;
      q_taken[wr_ptr]  <= ex_taken;
      q_target[wr_ptr] <= ex_target;
      q_trap[wr_ptr]   <= ex_trap;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= credit_cnt_t'(OUT_CREDITS);
    end else begin
      if (ex_valid) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at the power of two depth
      end
      if (send) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count   <= count + credit_cnt_t'(ex_valid) - credit_cnt_t'(send);
      credits <= credits + credit_cnt_t'(res_credit) - credit_cnt_t'(send);
    end
  end

  assign res_valid   = send;
  assign res_pc      = q_pc[rd_ptr];
  assign res_rd      = q_rd[rd_ptr];
  assign res_we      = q_we[rd_ptr];
  assign res_wdata   = q_wdata[rd_ptr];
  assign res_taken   = q_taken[rd_ptr];
  assign res_target  = q_target[rd_ptr];
  assign res_trap    = q_trap[rd_ptr];
  assign inst_credit = send;  // Freed slot goes back to the sender

  // Sender holds at most RESULT_DEPTH credits
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    ex_valid |-> (count != credit_cnt_t'(RESULT_DEPTH)) || send)
    else $error("result queue overflow");

  a_credit_bound: assert property (@(posedge clk) disable iff (rst)
    credits <= credit_cnt_t'(OUT_CREDITS))
    else $error("receiver returned more credits than it was given");

endmodule

`default_nettype wire

//--- source/exec_stage.sv
// Execute stage with ALU, branch compare, jump link and target, and rd writeback
`default_nettype none

module exec_stage import rv_slice_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     dec_valid,
  input  reg_idx_t dec_rs1,
  input  reg_idx_t dec_rs2,
  input  reg_idx_t dec_rd,
  input  xlen_t    dec_imm,
  input  alu_op_e  dec_alu_op,
  input  cmp_op_e  dec_cmp_op,
  input  logic     dec_use_imm,
  input  logic     dec_use_pc,
  input  logic     dec_writes_rd,
  input  logic     dec_is_branch,
  input  logic     dec_is_jal,
  input  logic     dec_is_jalr,
  input  logic     dec_trap,
  input  xlen_t    dec_pc,
  output logic     ex_valid,
  output xlen_t    ex_pc,
  output xlen_t    ex_wdata,
  output xlen_t    ex_target,
  output reg_idx_t ex_rd,
  output logic     ex_we,
  output logic     ex_taken,
  output logic     ex_trap
);

  xlen_t da, db, op_a, op_b, alu_y, wdata, target;
  logic  cond, jump, taken, we;

  assign jump  = dec_is_jal || dec_is_jalr;
  assign we    = dec_valid && dec_writes_rd;
  assign wdata = jump ? dec_pc + 32'd4 : alu_y;  // Link value for jumps

  // Write lands with the record, so the next instruction sees it
  reg_file u_rf (
    .clk (clk),
    .rst (rst),
    .ra  (dec_rs1),
    .rb  (dec_rs2),
    .da  (da),
    .db  (db),
    .we  (we),
    .wa  (dec_rd),
    .wd  (wdata)
  );

  assign op_a = dec_use_pc  ? dec_pc  : da;   // auipc
  assign op_b = dec_use_imm ? dec_imm : db;

  always_comb begin
    case (dec_alu_op)
      alu_add:  alu_y = op_a + op_b;
      alu_sub:  alu_y = op_a - op_b;
      alu_and:  alu_y = op_a & op_b;
      alu_or:   alu_y = op_a | op_b;
      alu_xor:  alu_y = op_a ^ op_b;
      alu_sll:  alu_y = op_a << op_b[4:0];
      alu_sra:  alu_y = xlen_t'($signed(op_a) >>> op_b[4:0]);
      alu_srl:  alu_y = op_a >> op_b[4:0];
      alu_slt:  alu_y = xlen_t'($signed(op_a) < $signed(op_b));
      alu_sltu: alu_y = xlen_t'(op_a < op_b);
      default:  alu_y = '0;
    endcase
  end

  // Compare always on register values
  always_comb begin
    case (dec_cmp_op)
      cmp_eq:  cond = da == db;
      cmp_ne:  cond = da != db;
      cmp_lt:  cond = $signed(da) < $signed(db);
      cmp_ge:  cond = $signed(da) >= $signed(db);
      cmp_ltu: cond = da < db;
      cmp_geu: cond = da >= db;
      default: cond = 1'b0;
    endcase
  end

  assign taken = jump || (dec_is_branch && cond);

  always_comb begin
    if (dec_is_jalr) begin
      target = (da + dec_imm) & ~xlen_t'(1);  // Bit 0 cleared
    end else if (dec_is_jal || dec_is_branch) begin
      target = dec_pc + dec_imm;
    end else begin
      target = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      ex_pc     <= dec_pc;
      ex_rd     <= dec_rd;
      ex_we     <= dec_writes_rd;
      ex_wdata  <= wdata;
      ex_taken  <= taken;
      ex_target <= target;
      ex_trap   <= dec_trap;
    end
  end

endmodule

`default_nettype wire

//--- source/reg_file.sv
// 32 entry register file with two combinational reads and one synchronous write port
`default_nettype none

module reg_file import rv_slice_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t ra,
  input  reg_idx_t rb,
  output xlen_t    da,
  output xlen_t    db,
  input  logic     we,
  input  reg_idx_t wa,
  input  xlen_t    wd
);

  xlen_t regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wa] <= wd;
    end
  end

  assign da = (ra == '0) ? '0 : regs[ra];  // x0 hardwired
  assign db = (rb == '0) ? '0 : regs[rb];

  // Decoder already drops rd zero writes
  a_no_x0_write: assert property (@(posedge clk) disable iff (rst) we |-> wa != '0)
    else $error("write to x0 reached the register file");

endmodule

`default_nettype wire

//--- source/decode_stage.sv
// Decode stage that registers the decoded instruction fields and pc for the execute stage
`default_nettype none

module decode_stage import rv_slice_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     inst_valid,
  input  inst_t    inst,
  input  xlen_t    inst_pc,
  output logic     dec_valid,
  output reg_idx_t dec_rs1,
  output reg_idx_t dec_rs2,
  output reg_idx_t dec_rd,
  output xlen_t    dec_imm,
  output alu_op_e  dec_alu_op,
  output cmp_op_e  dec_cmp_op,
  output logic     dec_use_imm,
  output logic     dec_use_pc,
  output logic     dec_writes_rd,
  output logic     dec_is_branch,
  output logic     dec_is_jal,
  output logic     dec_is_jalr,
  output logic     dec_trap,
  output xlen_t    dec_pc
);

  reg_idx_t rs1, rs2, rd;
  xlen_t    imm;
  alu_op_e  alu_op;
  cmp_op_e  cmp_op;
  logic     use_imm, use_pc, writes_rd, is_branch, is_jal, is_jalr, trap;

  inst_decoder u_dec (
    .inst      (inst),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .imm       (imm),
    .alu_op    (alu_op),
    .cmp_op    (cmp_op),
    .use_imm   (use_imm),
    .use_pc    (use_pc),
    .writes_rd (writes_rd),
    .is_branch (is_branch),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .trap      (trap)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= inst_valid;
    end
  end

  // Payload captured only with a valid instruction
  always_ff @(posedge clk) begin
    if (inst_valid) begin
      dec_rs1       <= rs1;
      dec_rs2       <= rs2;
      dec_rd        <= rd;
      dec_imm       <= imm;
      dec_alu_op    <= alu_op;
      dec_cmp_op    <= cmp_op;
      dec_use_imm   <= use_imm;
      dec_use_pc    <= use_pc;
      dec_writes_rd <= writes_rd;
      dec_is_branch <= is_branch;
      dec_is_jal    <= is_jal;
      dec_is_jalr   <= is_jalr;
      dec_trap      <= trap;
      dec_pc        <= inst_pc;
    end
  end

  a_inst_known: assert property (@(posedge clk) disable iff (rst)
    inst_valid |-> !$isunknown(inst))
    else $error("instruction word with unknown bits accepted");

endmodule

`default_nettype wire

//--- source/inst_decoder.sv
// Combinational RV32I decoder giving register indices, immediate, ALU and compare codes and flags
`default_nettype none

module inst_decoder import rv_slice_pkg::*; (
  input  inst_t    inst,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output reg_idx_t rd,
  output xlen_t    imm,
  output alu_op_e  alu_op,
  output cmp_op_e  cmp_op,
  output logic     use_imm,
  output logic     use_pc,
  output logic     writes_rd,
  output logic     is_branch,
  output logic     is_jal,
  output logic     is_jalr,
  output logic     trap
);

  logic [6:0] opcode;
  logic [2:0] f3;
  logic [6:0] f7;
  logic lui, auipc, jal, jalr, is_b, is_ld, is_st, is_opi, is_reg;
  logic f7_ok, f7_alt_ok, plain_f7;
  logic do_add, do_sub, do_and, do_or, do_xor, do_sll, do_srl, do_sra, do_slt, do_sltu;
  logic alu_ok;

  assign opcode = inst[6:0];
  assign f3     = inst[14:12];
  assign f7     = inst[31:25];

  assign lui    = opcode == op_lui;
  assign auipc  = opcode == op_auipc;
  assign jal    = opcode == op_jal;
  assign jalr   = opcode == op_jalr && f3 == f3_jalr;
  assign is_ld  = opcode == op_load;   // Only needed for the immediate
  assign is_st  = opcode == op_store;
  assign is_opi = opcode == op_imm;
  assign is_reg = opcode == op_reg;

  assign f7_ok     = f7 == f7_base;
  assign f7_alt_ok = f7 == f7_alt;
  assign plain_f7  = is_opi || (is_reg && f7_ok);  // Immediate form ignores funct7

  assign do_add  = lui || auipc || (plain_f7 && f3 == f3_add_sub);
  assign do_sub  = is_reg && f7_alt_ok && f3 == f3_add_sub;
  assign do_and  = plain_f7 && f3 == f3_and;
  assign do_or   = plain_f7 && f3 == f3_or;
  assign do_xor  = plain_f7 && f3 == f3_xor;
  assign do_slt  = plain_f7 && f3 == f3_slt;
  assign do_sltu = plain_f7 && f3 == f3_sltu;
  assign do_sll  = (is_opi || is_reg) && f7_ok && f3 == f3_sll;
  assign do_srl  = (is_opi || is_reg) && f7_ok && f3 == f3_sr;
  assign do_sra  = (is_opi || is_reg) && f7_alt_ok && f3 == f3_sr;

  assign alu_ok = |{do_add, do_sub, do_and, do_or, do_xor, do_sll, do_srl, do_sra,
                    do_slt, do_sltu};

  // Illegal branch funct3 leaves cmp_none
  always_comb begin
    cmp_op = cmp_none;
    if (opcode == op_branch) begin
      case (f3)
        f3_beq:  cmp_op = cmp_eq;
        f3_bne:  cmp_op = cmp_ne;
        f3_blt:  cmp_op = cmp_lt;
        f3_bge:  cmp_op = cmp_ge;
        f3_bltu: cmp_op = cmp_ltu;
        f3_bgeu: cmp_op = cmp_geu;
        default: cmp_op = cmp_none;
      endcase
    end
  end

  assign is_b = cmp_op != cmp_none;

  // First matching operation wins
  always_comb begin
    case (1'b1)
      do_add:           alu_op = alu_add;
      do_sub:           alu_op = alu_sub;
      do_and:           alu_op = alu_and;
      do_or:            alu_op = alu_or;
      do_xor:           alu_op = alu_xor;
      do_sll:           alu_op = alu_sll;
      do_sra || do_srl: alu_op = do_sra ? alu_sra : alu_srl;
      do_slt:           alu_op = alu_slt;
      do_sltu:          alu_op = alu_sltu;
      default:          alu_op = alu_none;
    endcase
  end

  always_comb begin
    case (1'b1)
      lui || auipc:              imm = {inst[31:12], 12'h000};
      jal:                       imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      is_b:                      imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      is_opi || is_ld || jalr:   imm = {{20{inst[31]}}, inst[31:20]};
      is_st:                     imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      default:                   imm = '0;
    endcase
  end

  assign rs1 = lui ? '0 : inst[19:15];  // lui adds to x0
  assign rs2 = inst[24:20];
  assign rd  = inst[11:7];

  assign use_imm   = lui || auipc || is_opi || jalr;
  assign use_pc    = auipc;
  assign is_branch = is_b;
  assign is_jal    = jal;
  assign is_jalr   = jalr;
  assign trap      = !(alu_ok || jal || jalr || is_b);  // Memory, CSR, fence, system, unknown
  assign writes_rd = (alu_ok || jal || jalr) && rd != '0;

endmodule

`default_nettype wire

//--- source/rv_slice_pkg.sv
// Widths, RV32I encodings, ALU and compare codes and depths; imported by every slice RTL file
`default_nettype none

package rv_slice_pkg;

  typedef logic [31:0] xlen_t;     // Register or data value
  typedef logic [31:0] inst_t;     // Instruction word
  typedef logic [4:0]  reg_idx_t;  // Register index
  typedef logic [2:0]  credit_cnt_t;

  // ALU operation codes with none at all ones
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sub  = 4'b0001,
    alu_and  = 4'b0010,
    alu_or   = 4'b0011,
    alu_xor  = 4'b0100,
    alu_sll  = 4'b0101,
    alu_sra  = 4'b0110,
    alu_srl  = 4'b0111,
    alu_slt  = 4'b1000,
    alu_sltu = 4'b1001,
    alu_none = 4'b1111
  } alu_op_e;

  typedef enum logic [2:0] {
    cmp_none = 3'd0,
    cmp_eq   = 3'd1,
    cmp_ne   = 3'd2,
    cmp_lt   = 3'd3,
    cmp_ge   = 3'd4,
    cmp_ltu  = 3'd5,
    cmp_geu  = 3'd6
  } cmp_op_e;

  // Major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_fence  = 7'b0001111;
  localparam logic [6:0] op_system = 7'b1110011;

  // Branch funct3
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // Arithmetic funct3, shared by register and immediate forms
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_sr      = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  localparam logic [2:0] f3_jalr    = 3'b000;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;  // sub and sra

  localparam int RESULT_DEPTH = 4;  // Queue slots and input credits
  localparam int OUT_CREDITS  = 2;

endpackage

`default_nettype wire
